/* Bender.yml */
package:
  name: ex_ma

sources:
  - include_dirs:
      - design
    files:
      - design/rv32i_types.sv
      - design/alu.sv
      - design/cmp.sv
      - design/instruction_execute.sv
      - design/mem_access.sv
      - design/ex_ma_top.sv
  - target: test
    include_dirs:
      - design
      - tb
    files:
      - tb/ex_ma_tb.sv

/* design/alu.sv */
`timescale 1ns/10ps

module alu (
  input  rv32i_types::alu_ops    aluop,
  input  rv32i_types::rv32i_word a,
  input  rv32i_types::rv32i_word b,
  output rv32i_types::rv32i_word f
);
  import rv32i_types::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];  // only the low five bits count for a shift

  always_comb begin
    case (aluop)
      add:
        f = a + b;
      sub:
        f = a - b;
      sll:
        f = a << shamt;
      srl:
        f = a >> shamt;
      sra:
        f = rv32i_word'($signed(a) >>> shamt);  // fills with the sign bit of a
      slt:
        f = rv32i_word'($signed(a) < $signed(b));
      sltu:
        f = rv32i_word'(a < b);
      axor:
        f = a ^ b;
      aor:
        f = a | b;
      aand:
        f = a & b;
      default:
        f = a + b;  // unused codes behave like add
    endcase
  end

endmodule

/* design/cmp.sv */
`timescale 1ns/10ps

module cmp (
  input  rv32i_types::branch_funct3_t cmpop,
  input  rv32i_types::rv32i_word      rs1_out,
  input  rv32i_types::rv32i_word      cmp_in,
  output logic                        br_en
);
  import rv32i_types::*;

  always_comb begin
    case (cmpop)
      beq:
        br_en = (rs1_out == cmp_in);
      bne:
        br_en = (rs1_out != cmp_in);
      blt:
        br_en = ($signed(rs1_out) < $signed(cmp_in));
      bge:
        br_en = ($signed(rs1_out) >= $signed(cmp_in));
      bltu:
        br_en = (rs1_out < cmp_in);
      bgeu:
        br_en = (rs1_out >= cmp_in);
      default:
        br_en = 1'b0;  // funct3 010 and 011 are not branches
    endcase
  end

endmodule

/* design/ex_ma_top.sv */
`timescale 1ns/10ps
`include "rv32i_defs.svh"

module ex_ma_top (
  input  logic                   clk,
  input  logic                   rst,
  input  rv32i_types::ex_in_t    ex_in,
  input  logic                   if_stall,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output rv32i_types::rv32i_word wb_adr,
  output logic [`RV_NBYTES-1:0]  wb_sel,
  output rv32i_types::rv32i_word wb_dat_o,
  input  rv32i_types::rv32i_word wb_dat_i,
  input  logic                   wb_ack,
  output rv32i_types::wb_out_t   wb
);
  import rv32i_types::*;

  ex_out_t ex_out;    // execute register feeding memory access
  logic    ma_stall;  // held back while a load or store waits for ack

  instruction_execute instruction_execute_i (
    .clk      (clk),
    .rst      (rst),
    .ex_in    (ex_in),
    .if_stall (if_stall),
    .ma_stall (ma_stall),
    .ex_out   (ex_out)
  );

  mem_access mem_access_i (
    .clk      (clk),
    .rst      (rst),
    .ex_out   (ex_out),
    .if_stall (if_stall),
    .ma_stall (ma_stall),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_dat_o (wb_dat_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack),
    .wb       (wb)
  );

endmodule

/* design/instruction_execute.sv */
`timescale 1ns/10ps
`include "rv32i_defs.svh"

module instruction_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  rv32i_types::ex_in_t   ex_in,
  input  logic                  if_stall,
  input  logic                  ma_stall,
  output rv32i_types::ex_out_t  ex_out
);
  import rv32i_types::*;

  rv32i_word             alu_f;
  logic                  br_en;
  logic [1:0]            offset;
  logic [`RV_NBYTES-1:0] byte_en;
  logic                  stall;

  alu alu_i (
    .aluop (ex_in.ctrl.aluop),
    .a     (ex_in.alu_in_1),
    .b     (ex_in.alu_in_2),
    .f     (alu_f)
  );

  cmp cmp_i (
    .cmpop   (ex_in.ctrl.cmpop),
    .rs1_out (ex_in.rs1_out),
    .cmp_in  (ex_in.cmp_in),
    .br_en   (br_en)
  );

  assign offset = alu_f[1:0];  // byte offset of the effective address
  assign stall  = if_stall | ma_stall;

  // lanes that fall above the top byte are simply lost for misaligned accesses
  always_comb begin
    case (load_funct3_t'(ex_in.instruction[14:12]))
      lw: begin
        byte_en = 4'b1111 << offset;
      end
      lh, lhu: begin
        byte_en = 4'b0011 << offset;
      end
      lb, lbu: begin
        byte_en = 4'b0001 << offset;
      end
      default: begin
        byte_en = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_out <= '0;  // every control bit reads as a bubble
    end else if (!stall) begin
      ex_out.ctrl            <= ex_in.ctrl;
      ex_out.instruction     <= ex_in.instruction;
      ex_out.pc              <= ex_in.pc;
      ex_out.alu_out         <= alu_f;
      ex_out.rs2_out         <= ex_in.rs2;
      ex_out.br_en           <= br_en;
      ex_out.mem_byte_enable <= byte_en;
    end
  end

endmodule

/* design/mem_access.sv */
`timescale 1ns/10ps
`include "rv32i_defs.svh"

module mem_access (
  input  logic                   clk,
  input  logic                   rst,
  input  rv32i_types::ex_out_t   ex_out,
  input  logic                   if_stall,
  output logic                   ma_stall,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output rv32i_types::rv32i_word wb_adr,
  output logic [`RV_NBYTES-1:0]  wb_sel,
  output rv32i_types::rv32i_word wb_dat_o,
  input  rv32i_types::rv32i_word wb_dat_i,
  input  logic                   wb_ack,
  output rv32i_types::wb_out_t   wb
);
  import rv32i_types::*;

  logic       mem_op;
  logic       done;        // the bus already acked this instruction
  logic       advance;
  logic [1:0] offset;
  logic [4:0] lane_shift;
  rv32i_word  ack_data;    // load word kept while if_stall holds the stage
  rv32i_word  rdata_raw;
  load_data_u rdata_lane;
  rv32i_word  load_value;

  assign mem_op     = ex_out.ctrl.mem_read | ex_out.ctrl.mem_write;
  assign offset     = ex_out.alu_out[1:0];
  assign lane_shift = {offset, 3'b000};  // eight bits per byte of offset

  // a request stays up from the moment the instruction arrives until its ack
  assign wb_cyc   = mem_op & ~done;
  assign wb_stb   = mem_op & ~done;
  assign wb_we    = ex_out.ctrl.mem_write;
  assign wb_adr   = {ex_out.alu_out[`RV_XLEN-1:2], 2'b00};
  assign wb_sel   = ex_out.mem_byte_enable;
  assign wb_dat_o = ex_out.rs2_out << lane_shift;  // move store data onto its lanes

  assign ma_stall = mem_op & ~done & ~wb_ack;
  assign advance  = ~(if_stall | ma_stall);

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else if (advance) begin
      done <= 1'b0;
    end else if (wb_stb && wb_ack) begin
      done <= 1'b1;  // the ack came while if_stall was high
    end
  end

  always_ff @(posedge clk) begin
    if (wb_stb && wb_ack) begin
      ack_data <= wb_dat_i;
    end
  end

  assign rdata_raw  = done ? ack_data : wb_dat_i;
  assign rdata_lane = rdata_raw >> lane_shift;  // addressed byte ends up in lane 0

  always_comb begin
    case (load_funct3_t'(ex_out.instruction[14:12]))
      lb: begin
        load_value = {{(`RV_XLEN-`RV_BYTE_W){rdata_lane.bytes[0][`RV_BYTE_W-1]}},
                      rdata_lane.bytes[0]};
      end
      lbu: begin
        load_value = {{(`RV_XLEN-`RV_BYTE_W){1'b0}}, rdata_lane.bytes[0]};
      end
      lh: begin
        load_value = {{(`RV_XLEN-2*`RV_BYTE_W){rdata_lane.halves[0][2*`RV_BYTE_W-1]}},
                      rdata_lane.halves[0]};
      end
      lhu: begin
        load_value = {{(`RV_XLEN-2*`RV_BYTE_W){1'b0}}, rdata_lane.halves[0]};
      end
      default: begin
        load_value = rdata_lane;  // lw takes the whole shifted word
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb <= '0;
    end else if (advance) begin
      wb.ctrl        <= ex_out.ctrl;
      wb.instruction <= ex_out.instruction;
      wb.pc          <= ex_out.pc;
      wb.alu_out     <= ex_out.alu_out;
      wb.mem_rdata   <= ex_out.ctrl.mem_read ? load_value : '0;
      wb.br_en       <= ex_out.br_en;
    end
  end

  // the execute stage must hand over a lane mask for every memory access
  sel_nonzero: assert property (
    @(posedge clk) disable iff (rst)
    wb_stb |-> (wb_sel != '0)
  ) else $error("wb_sel is zero during a request");

  req_stable: assert property (
    @(posedge clk) disable iff (rst)
    (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_sel) && $stable(wb_dat_o))
  ) else $error("request fields changed before ack");

endmodule

/* design/rv32i_defs.svh */
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// widths shared by the execute and memory-access stages

// data path and address width of the integer core
`define RV_XLEN   32

// number of byte lanes in one data word
`define RV_NBYTES 4

// width of a single byte lane on the data bus
`define RV_BYTE_W 8

`endif

/* design/rv32i_types.sv */
`include "rv32i_defs.svh"

package rv32i_types;

  typedef logic [`RV_XLEN-1:0] rv32i_word;

  // alu operation select carried in the control word
  typedef enum logic [3:0] {
    add  = 4'b0000,
    sll  = 4'b0001,
    slt  = 4'b0010,
    sltu = 4'b0011,
    axor = 4'b0100,
    srl  = 4'b0101,
    aor  = 4'b0110,
    aand = 4'b0111,
    sub  = 4'b1000,
    sra  = 4'b1101
  } alu_ops;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  // store funct3 uses the same width codes as the loads
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef struct packed {
    alu_ops         aluop;
    branch_funct3_t cmpop;
    logic           mem_read;
    logic           mem_write;
    logic           load_regfile;  // an all zero word is a bubble
  } rv32i_control_word;

  typedef struct packed {
    rv32i_word         pc;
    rv32i_word         instruction;
    rv32i_word         alu_in_1;
    rv32i_word         alu_in_2;
    rv32i_word         rs1_out;
    rv32i_word         rs2;
    rv32i_word         cmp_in;
    rv32i_control_word ctrl;
  } ex_in_t;

  typedef struct packed {
    rv32i_control_word      ctrl;
    rv32i_word              instruction;
    rv32i_word              pc;
    rv32i_word              alu_out;
    rv32i_word              rs2_out;
    logic                   br_en;
    logic [`RV_NBYTES-1:0]  mem_byte_enable;
  } ex_out_t;

  typedef struct packed {
    rv32i_control_word ctrl;
    rv32i_word         instruction;
    rv32i_word         pc;
    rv32i_word         alu_out;
    rv32i_word         mem_rdata;  // zero for anything that is not a load
    logic              br_en;
  } wb_out_t;

  typedef union packed {
    logic [`RV_NBYTES-1:0][`RV_BYTE_W-1:0]       bytes;
    logic [`RV_NBYTES/2-1:0][2*`RV_BYTE_W-1:0]   halves;
  } load_data_u;

endpackage

/* src.f */
+incdir+design
+incdir+tb
design/rv32i_types.sv
design/alu.sv
design/cmp.sv
design/instruction_execute.sv
design/mem_access.sv
design/ex_ma_top.sv
tb/ex_ma_tb.sv

/* tb/ex_ma_model.svh */
`ifndef EX_MA_MODEL_SVH
`define EX_MA_MODEL_SVH

function automatic logic [`RV_NBYTES-1:0] lane_mask(input logic [2:0] f3, input logic [1:0] off);
  logic [`RV_NBYTES-1:0] m;
  case (f3)
    3'b010: m = (off == 0) ? 4'b1111 : (off == 1) ? 4'b1110 : (off == 2) ? 4'b1100 : 4'b1000;
    3'b001, 3'b101: m = (off == 0) ? 4'b0011 : (off == 1) ? 4'b0110 : (off == 2) ? 4'b1100 : 4'b1000;
    3'b000, 3'b100: m = 4'b0001 << off;  // one lane per byte access
    default: m = 4'b1111;
  endcase
  return m;
endfunction

function automatic wb_out_t ref_wb(input ex_in_t x, input rv32i_word mem [64]);
  wb_out_t   r;
  rv32i_word a;
  rv32i_word b;
  rv32i_word w;
  r = '0;
  r.ctrl = x.ctrl;
  r.instruction = x.instruction;
  r.pc = x.pc;
  a = x.alu_in_1;
  b = x.alu_in_2;
  case (x.ctrl.aluop)
    sub:     r.alu_out = a - b;
    sll:     r.alu_out = a << b[4:0];
    srl:     r.alu_out = a >> b[4:0];
    sra:     r.alu_out = rv32i_word'($signed(a) >>> b[4:0]);
    slt:     r.alu_out = {31'd0, $signed(a) < $signed(b)};
    sltu:    r.alu_out = {31'd0, a < b};
    axor:    r.alu_out = a ^ b;
    aor:     r.alu_out = a | b;
    aand:    r.alu_out = a & b;
    default: r.alu_out = a + b;
  endcase
  case (x.ctrl.cmpop)
    beq:     r.br_en = (x.rs1_out == x.cmp_in);
    bne:     r.br_en = (x.rs1_out != x.cmp_in);
    blt:     r.br_en = ($signed(x.rs1_out) < $signed(x.cmp_in));
    bge:     r.br_en = ($signed(x.rs1_out) >= $signed(x.cmp_in));
    bltu:    r.br_en = (x.rs1_out < x.cmp_in);
    bgeu:    r.br_en = (x.rs1_out >= x.cmp_in);
    default: r.br_en = 1'b0;
  endcase
  if (x.ctrl.mem_read) begin
    w = mem[r.alu_out[7:2]] >> (8 * r.alu_out[1:0]);  // addressed byte moves to bit 0
    case (x.instruction[14:12])
      3'b000:  r.mem_rdata = {{24{w[7]}}, w[7:0]};
      3'b100:  r.mem_rdata = {24'd0, w[7:0]};
      3'b001:  r.mem_rdata = {{16{w[15]}}, w[15:0]};
      3'b101:  r.mem_rdata = {16'd0, w[15:0]};
      default: r.mem_rdata = w;
    endcase
  end
  return r;
endfunction

task automatic fail_run(input string msg);
  err_count++;
  $display("%s", msg);
  $display("Errors found");
  $fatal(1, "stopped at the first error");
endtask

task automatic check_wb(input wb_out_t got, input wb_out_t exp);
  if (got !== exp)
    fail_run($sformatf("Mismatch at %0t: wb pc %h alu_out %h/%h mem_rdata %h/%h br_en %b/%b",
      $time, got.pc, got.alu_out, exp.alu_out, got.mem_rdata, exp.mem_rdata, got.br_en,
      exp.br_en));
endtask

task automatic check_bus(input store_req_t got);
  store_req_t exp;
  if (bus_q.size() == 0)
    fail_run("a store request appeared with no store outstanding");
  exp = bus_q.pop_front();
  if (got !== exp)
    fail_run($sformatf("Mismatch at %0t: store adr %h/%h sel %b/%b dat %h/%h", $time,
      got.adr, exp.adr, got.sel, exp.sel, got.dat, exp.dat));
endtask

// slave answers each request once, after zero to three wait cycles
task automatic serve_bus();
  int         wait_left;
  logic       busy;
  store_req_t req;
  busy = 1'b0;
  wait_left = 0;
  forever begin
    @(negedge clk);
    wb_ack = 1'b0;
    if (wb_cyc !== wb_stb)
      fail_run("wb_cyc and wb_stb did not rise and fall together");
    if (!wb_stb) begin
      busy = 1'b0;
    end else begin
      if (!busy) begin
        busy = 1'b1;
        wait_left = $random(seed) & 3;
      end
      if (wait_left == 0) begin
        if (wb_we) begin
          for (int l = 0; l < `RV_NBYTES; l++)
            if (wb_sel[l]) model_mem[wb_adr[7:2]][8*l +: 8] = wb_dat_o[8*l +: 8];
          req.adr = wb_adr;
          req.sel = wb_sel;
          req.dat = wb_dat_o;
          check_bus(req);
        end else begin
          wb_dat_i = model_mem[wb_adr[7:2]];
        end
        wb_ack = 1'b1;
        busy = 1'b0;
      end else begin
        wait_left--;
      end
    end
  end
endtask

`endif

/* tb/ex_ma_tb.sv */
`timescale 1ns/10ps
`include "rv32i_defs.svh"

module ex_ma_tb;
  import rv32i_types::*;

  typedef struct packed {
    rv32i_word             adr;
    logic [`RV_NBYTES-1:0] sel;
    rv32i_word             dat;
  } store_req_t;  // one expected write request on the bus

  localparam int N_INSTR    = 192;
  localparam int RST_CYCLES = 5;
  localparam int LIMIT      = N_INSTR * 6 + 2 * RST_CYCLES;

  logic                  clk;
  logic                  rst;
  logic                  if_stall;
  ex_in_t                ex_in;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  rv32i_word             wb_adr;
  logic [`RV_NBYTES-1:0] wb_sel;
  rv32i_word             wb_dat_o;
  rv32i_word             wb_dat_i;
  logic                  wb_ack;
  wb_out_t               wb;

  integer     seed = 32'h7b63_c567;
  int         cycles;
  int         err_count;
  logic       stall_mode;  // random if_stall pulses while set
  logic       retire;      // wb took a new value at the last rising edge
  rv32i_word  pc_next;
  rv32i_word  model_mem [64];   // memory behind the bus
  rv32i_word  shadow_mem [64];  // same memory in program order
  wb_out_t    exp_q [$];
  store_req_t bus_q [$];
  alu_ops         ops [10] = '{add, sll, slt, sltu, axor, srl, sra, aor, aand, sub};
  branch_funct3_t bops [6] = '{beq, bne, blt, bge, bltu, bgeu};
  logic [2:0]     widths [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

  `include "ex_ma_model.svh"

  ex_ma_top ex_ma_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: the pipeline did not finish within %0d cycles", LIMIT);
      $display("Errors found");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // both stage registers move on when neither stall is high
  always @(posedge clk) begin
    retire <= !rst && !if_stall && !(wb_stb && !wb_ack);
  end

  always @(negedge clk) begin
    if (retire && wb.ctrl != '0) begin
      if (exp_q.size() == 0)
        fail_run("an instruction retired that was never issued");
      check_wb(wb, exp_q.pop_front());
    end
  end

  function automatic ex_in_t random_instr(input int kind);
    ex_in_t x;
    x = '0;
    x.instruction = $random(seed);
    x.alu_in_1 = $random(seed);
    x.alu_in_2 = $random(seed);
    x.rs1_out = $random(seed);
    x.rs2 = $random(seed);
    x.cmp_in = x.rs2[0] ? x.rs1_out : $random(seed);  // equal operands half the time
    x.ctrl.aluop = ops[$unsigned($random(seed)) % 10];
    x.ctrl.cmpop = bops[$unsigned($random(seed)) % 6];
    x.ctrl.load_regfile = (kind != 2);
    if (kind >= 2) begin
      x.ctrl.aluop = add;
      x.ctrl.mem_read = (kind == 3);
      x.ctrl.mem_write = (kind == 2);
      x.alu_in_1 = x.alu_in_1 & 32'h0000_00fc;  // stay inside the 64-word model
      x.alu_in_2 = x.alu_in_2 & 32'h3;
      x.instruction[14:12] = widths[$unsigned($random(seed)) % ((kind == 2) ? 3 : 5)];
    end
    return x;
  endfunction

  task automatic issue(input ex_in_t x);
    store_req_t req;
    rv32i_word  addr;
    logic       accepted;
    x.pc = pc_next;
    pc_next += 4;
    exp_q.push_back(ref_wb(x, shadow_mem));
    if (x.ctrl.mem_write) begin
      addr = x.alu_in_1 + x.alu_in_2;
      req.adr = {addr[31:2], 2'b00};
      req.sel = lane_mask(x.instruction[14:12], addr[1:0]);
      req.dat = x.rs2 << (8 * addr[1:0]);
      bus_q.push_back(req);
      for (int l = 0; l < `RV_NBYTES; l++)
        if (req.sel[l]) shadow_mem[addr[7:2]][8*l +: 8] = req.dat[8*l +: 8];
    end
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      ex_in = x;
      if_stall = stall_mode ? (($random(seed) & 3) == 0) : 1'b0;
      #1;
      accepted = !(if_stall || (wb_stb && !wb_ack));  // the edge ahead takes ex_in
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    ex_in = '0;
    if_stall = 1'b0;
    @(negedge clk);
    if (wb_cyc || wb_stb || wb.ctrl != '0)
      fail_run("reset did not clear the bus request or the writeback register");
    repeat (RST_CYCLES - 1) @(negedge clk);
    rst = 1'b0;
    exp_q.delete();
    bus_q.delete();
    shadow_mem = model_mem;  // stores cut off by reset may or may not have landed
    repeat (2) begin
      @(negedge clk);
      if (wb_cyc || wb_stb || wb.ctrl != '0)
        fail_run("after reset the bus is active or wb is not a bubble");
    end
  endtask

  initial begin
    ex_in_t x;
    rst = 1'b1;
    ex_in = '0;
    if_stall = 1'b0;
    wb_ack = 1'b0;
    wb_dat_i = '0;
    stall_mode = 1'b0;
    cycles = 0;
    err_count = 0;
    pc_next = 32'h0000_1000;
    for (int i = 0; i < 64; i++)
      model_mem[i] = 32'h9e37_79b9 * (i + 1);
    shadow_mem = model_mem;
    fork
      serve_bus();
    join_none
    apply_reset();
    for (int i = 0; i < 100; i++) begin
      x = random_instr(i % 2);
      x.ctrl.aluop = ops[i % 10];
      x.ctrl.cmpop = bops[i % 6];
      issue(x);
    end
    for (int w = 0; w < 3; w++)
      for (int off = 0; off < 4; off++) begin
        x = random_instr(2);
        x.instruction[14:12] = widths[w];
        x.alu_in_1 = 32'h40 + 4 * (w * 4 + off);
        x.alu_in_2 = off;
        issue(x);
      end
    for (int f = 0; f < 5; f++)
      for (int off = 0; off < 4; off++) begin
        x = random_instr(3);
        x.instruction[14:12] = widths[f];
        x.alu_in_1 = 32'h40 + 4 * ((f + off * 3) % 12);  // words written just above
        x.alu_in_2 = off;
        issue(x);
      end
    stall_mode = 1'b1;
    repeat (40) issue(random_instr($unsigned($random(seed)) % 4));
    repeat (10) issue(random_instr($unsigned($random(seed)) % 4));
    stall_mode = 1'b0;
    apply_reset();
    repeat (10) issue(random_instr($unsigned($random(seed)) % 4));
    @(negedge clk);
    ex_in = '0;
    while (exp_q.size() != 0 || bus_q.size() != 0)
      @(negedge clk);
    repeat (3) @(negedge clk);
    if (err_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule
